//--- blast_ctrl_fsm.sv
`timescale 1ns/1ps

module blast_ctrl_fsm (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       app_ready,
   input  logic [7:0]                 app_code,
   input  blast_pkg::subject_header_t hdr,
   output blast_pkg::ctrl_state_t     state,
   output logic                       rd_query,
   output logic                       rd_subject,
   output logic                       wr_hit,
   output logic                       wr_header,
   output logic                       first_pass,
   output logic                       array_reset
);

   blast_pkg::ctrl_state_t next_state;

   // read phase and hit window counters
   logic [2:0]  rd_cnt;
   logic [5:0]  win_cnt;
   logic [2:0]  rd_last_idx;
   logic        read_last;
   logic        window_last;
   logic        finished;
   logic        query_cmd;
   logic [31:0] subject_total;

   assign rd_query   = (state == blast_pkg::READ_QUERY);
   assign rd_subject = (state == blast_pkg::READ_SUBJECT);
   assign wr_hit     = (state == blast_pkg::WRITE_HIT);
   assign wr_header  = (state == blast_pkg::WRITE_HEADER);

   assign query_cmd = (state == blast_pkg::IDLE) && app_ready &&
                      (app_code == blast_pkg::CMD_READ_QUERY);

   // header word plus full buffer on the first pass, refill words afterwards
   always_comb begin
      if (rd_query) begin
         rd_last_idx = 3'(blast_pkg::BUF_WORDS - 1);
      end else if (first_pass) begin
         rd_last_idx = 3'(blast_pkg::BUF_WORDS);
      end else begin
         rd_last_idx = 3'(blast_pkg::REFILL_WORDS - 1);
      end
   end

   assign read_last   = (rd_query || rd_subject) && (rd_cnt == rd_last_idx);
   assign window_last = wr_hit && (win_cnt == 6'(blast_pkg::HIT_WINDOW - 1));
   assign finished    = (subject_total >= hdr.subject_length);

   always_comb begin
      next_state = state;
      case (state)
         blast_pkg::IDLE: begin
            if (app_ready) begin
               if (app_code == blast_pkg::CMD_READ_QUERY) begin
                  next_state = blast_pkg::READ_QUERY;
               end else if (app_code == blast_pkg::CMD_READ_SUBJECT) begin
                  next_state = blast_pkg::READ_SUBJECT;
               end
            end
         end
         blast_pkg::READ_QUERY: begin
            if (read_last) begin
               next_state = blast_pkg::IDLE;
            end
         end
         blast_pkg::READ_SUBJECT: begin
            if (read_last) begin
               next_state = blast_pkg::WRITE_HIT;
            end
         end
         blast_pkg::WRITE_HIT: begin
            if (window_last) begin
               next_state = finished ? blast_pkg::WRITE_HEADER : blast_pkg::READ_SUBJECT;
            end
         end
         blast_pkg::WRITE_HEADER: begin
            next_state = blast_pkg::IDLE;
         end
         default: begin
            next_state = blast_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= blast_pkg::IDLE;
         rd_cnt      <= '0;
         win_cnt     <= '0;
         first_pass  <= 1'b1;
         array_reset <= 1'b0;
      end else begin
         state       <= next_state;
         array_reset <= query_cmd;

         if ((rd_query || rd_subject) && !read_last) begin
            rd_cnt <= rd_cnt + 3'd1;
         end else begin
            rd_cnt <= '0;
         end

         // wraps to zero at the end of each window
         if (wr_hit) begin
            win_cnt <= win_cnt + 6'd1;
         end else begin
            win_cnt <= '0;
         end

         if (state == blast_pkg::IDLE || wr_header) begin
            first_pass <= 1'b1;
         end else if (rd_subject && read_last) begin
            first_pass <= 1'b0;
         end
      end
   end

   // characters streamed so far for this subject
   always_ff @(posedge clk) begin
      if (reset || state == blast_pkg::IDLE || wr_header) begin
         subject_total <= '0;
      end else if (rd_subject && read_last) begin
         subject_total <= subject_total + 32'(blast_pkg::SUBJECT_CHARS);
      end
   end

endmodule

//--- blast_pkg.sv
package blast_pkg;

   // memory word and address widths
   localparam int MEM_DATA_W = 64;
   localparam int MEM_ADDR_W = 14;

   // character and hit record field widths
   localparam int CHAR_W      = 3;
   localparam int HIT_FIELD_W = 8;

   // buffer depth and stream lengths
   localparam int BUF_WORDS     = 6;
   localparam int QUERY_CHARS   = 128;
   localparam int SUBJECT_CHARS = 64;
   localparam int REFILL_WORDS  = 3;
   localparam int HIT_WINDOW    = 64;

   typedef enum logic [2:0] {
      IDLE,
      READ_QUERY,
      READ_SUBJECT,
      WRITE_HIT,
      WRITE_HEADER
   } ctrl_state_t;

   // host command codes
   typedef enum logic [7:0] {
      CMD_READ_QUERY   = 8'hAA,
      CMD_READ_SUBJECT = 8'hBB,
      CMD_FINISHED     = 8'hEE
   } app_cmd_t;

   // one character towards the seed array
   typedef struct packed {
      logic              valid;
      logic [CHAR_W-1:0] code;
   } char_strobe_t;

   // any non-zero field marks a found record
   typedef struct packed {
      logic [HIT_FIELD_W-1:0] q_addr;
      logic [HIT_FIELD_W-1:0] s_addr;
      logic [HIT_FIELD_W-1:0] length;
      logic [HIT_FIELD_W-1:0] score;
   } hit_record_t;

   typedef struct packed {
      logic [MEM_DATA_W/2-1:0] subject_id;
      logic [MEM_DATA_W/2-1:0] subject_length;
   } subject_header_t;

endpackage

//--- blast_top.sv
`timescale 1ns/1ps

module blast_top #(
   parameter int QUERY_BASE   = 0,
   parameter int SUBJECT_BASE = 12,
   parameter int HIT_BASE     = 16262
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    app_ready,
   input  logic [7:0]              app_code,
   input  logic [63:0]             memory_readdata,
   input  blast_pkg::hit_record_t  hit,
   output logic [13:0]             memory_address,
   output logic                    memory_write,
   output logic [63:0]             memory_writedata,
   output blast_pkg::char_strobe_t query_char,
   output blast_pkg::char_strobe_t subject_char,
   output logic                    hit_read,
   output logic                    array_reset,
   output logic [31:0]             subject_id,
   output logic [31:0]             subject_length
);

   // phase levels, one-hot
   logic rd_query;
   logic rd_subject;
   logic wr_hit;
   logic wr_header;
   logic first_pass;

   blast_pkg::subject_header_t hdr;

   assign hit_read       = wr_hit;
   assign subject_id     = hdr.subject_id;
   assign subject_length = hdr.subject_length;

   blast_ctrl_fsm u_fsm (
      .clk         (clk),
      .reset       (reset),
      .app_ready   (app_ready),
      .app_code    (app_code),
      .hdr         (hdr),
      .state       (),
      .rd_query    (rd_query),
      .rd_subject  (rd_subject),
      .wr_hit      (wr_hit),
      .wr_header   (wr_header),
      .first_pass  (first_pass),
      .array_reset (array_reset)
   );

   query_loader u_query (
      .clk             (clk),
      .reset           (reset),
      .rd_query        (rd_query),
      .memory_readdata (memory_readdata),
      .query_char      (query_char)
   );

   subject_loader u_subject (
      .clk             (clk),
      .reset           (reset),
      .rd_subject      (rd_subject),
      .first_pass      (first_pass),
      .memory_readdata (memory_readdata),
      .subject_char    (subject_char),
      .hdr             (hdr)
   );

   mem_port #(
      .QUERY_BASE   (QUERY_BASE),
      .SUBJECT_BASE (SUBJECT_BASE),
      .HIT_BASE     (HIT_BASE)
   ) u_mem (
      .clk              (clk),
      .reset            (reset),
      .rd_query         (rd_query),
      .rd_subject       (rd_subject),
      .wr_hit           (wr_hit),
      .wr_header        (wr_header),
      .hit              (hit),
      .hdr              (hdr),
      .memory_address   (memory_address),
      .memory_write     (memory_write),
      .memory_writedata (memory_writedata)
   );

endmodule

//--- build.f
+incdir+.
blast_pkg.sv
blast_ctrl_fsm.sv
query_loader.sv
subject_loader.sv
mem_port.sv
blast_top.sv
tb_blast_top.sv

//--- mem_port.sv
`timescale 1ns/1ps

module mem_port #(
   parameter int QUERY_BASE   = 0,
   parameter int SUBJECT_BASE = 12,
   parameter int HIT_BASE     = 16262
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       rd_query,
   input  logic                       rd_subject,
   input  logic                       wr_hit,
   input  logic                       wr_header,
   input  blast_pkg::hit_record_t     hit,
   input  blast_pkg::subject_header_t hdr,
   output logic [13:0]                memory_address,
   output logic                       memory_write,
   output logic [63:0]                memory_writedata
);

   localparam int AW = blast_pkg::MEM_ADDR_W;

   localparam logic [AW-1:0] QUERY_START   = AW'(QUERY_BASE);
   localparam logic [AW-1:0] SUBJECT_START = AW'(SUBJECT_BASE);
   localparam logic [AW-1:0] HEADER_ADDR   = AW'(HIT_BASE);
   // records go just above the header word
   localparam logic [AW-1:0] HIT_START     = AW'(HIT_BASE + 1);

   logic [AW-1:0] query_addr;
   logic [AW-1:0] subject_addr;
   logic [AW-1:0] hit_addr;
   logic [31:0]   hit_bytes;
   logic          idle;
   logic          found;

   assign idle  = !(rd_query || rd_subject || wr_hit || wr_header);
   assign found = |hit;

   always_ff @(posedge clk) begin
      if (reset || idle) begin
         query_addr   <= QUERY_START;
         subject_addr <= SUBJECT_START;
         hit_addr     <= HIT_START;
      end else begin
         if (rd_query) begin
            query_addr <= query_addr + 1'b1;
         end
         // continues across passes of the same subject
         if (rd_subject) begin
            subject_addr <= subject_addr + 1'b1;
         end
         if (wr_hit) begin
            if (hit_addr == '1) begin
               hit_addr <= HIT_START;
            end else begin
               hit_addr <= hit_addr + 1'b1;
            end
         end
      end
   end

   // 8 bytes per stored record
   always_ff @(posedge clk) begin
      if (reset || wr_header) begin
         hit_bytes <= '0;
      end else if (wr_hit && found) begin
         hit_bytes <= hit_bytes + 32'd8;
      end
   end

   always_comb begin
      if (rd_query) begin
         memory_address = query_addr;
      end else if (rd_subject) begin
         memory_address = subject_addr;
      end else if (wr_hit) begin
         memory_address = hit_addr;
      end else if (wr_header) begin
         memory_address = HEADER_ADDR;
      end else begin
         memory_address = '0;
      end
   end

   assign memory_write     = wr_header || (wr_hit && found);
   assign memory_writedata = wr_header ? {hdr.subject_id, hit_bytes} : {32'b0, hit};

endmodule

//--- query_loader.sv
`timescale 1ns/1ps

module query_loader (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    rd_query,
   input  logic [63:0]             memory_readdata,
   output blast_pkg::char_strobe_t query_char
);

   localparam int BUF_W = blast_pkg::BUF_WORDS * blast_pkg::MEM_DATA_W;
   localparam int CNT_W = $clog2(blast_pkg::QUERY_CHARS + 1);

   logic [BUF_W-1:0] query_buf;
   logic [CNT_W-1:0] chars_left;
   logic             stream_on;

   // stream runs once the read phase is over
   assign stream_on  = !rd_query && (chars_left != '0);
   assign query_char = '{valid: stream_on, code: query_buf[blast_pkg::CHAR_W-1:0]};

   always_ff @(posedge clk) begin
      if (reset) begin
         chars_left <= '0;
      end else if (rd_query) begin
         chars_left <= CNT_W'(blast_pkg::QUERY_CHARS);
      end else if (stream_on) begin
         chars_left <= chars_left - 1'b1;
      end
   end

   // new words enter at the top, first word ends up lowest
   always_ff @(posedge clk) begin
      if (rd_query) begin
         query_buf <= {memory_readdata, query_buf[BUF_W-1:blast_pkg::MEM_DATA_W]};
      end else if (stream_on) begin
         query_buf <= query_buf >> blast_pkg::CHAR_W;
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_blast_top \
   -f build.f -o sim_tb_blast_top > build.log 2>&1 \
   && ./obj_dir/sim_tb_blast_top > sim.log 2>&1 \
   || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "All checks passed" sim.log \
   && echo "PASS" \
   || { echo "FAIL, see sim.log"; exit 1; }

//--- subject_loader.sv
`timescale 1ns/1ps

module subject_loader (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       rd_subject,
   input  logic                       first_pass,
   input  logic [63:0]                memory_readdata,
   output blast_pkg::char_strobe_t    subject_char,
   output blast_pkg::subject_header_t hdr
);

   localparam int WORD_W = blast_pkg::MEM_DATA_W;
   localparam int BUF_W  = blast_pkg::BUF_WORDS * WORD_W;
   localparam int HALF_W = blast_pkg::REFILL_WORDS * WORD_W;
   localparam int CNT_W  = $clog2(blast_pkg::SUBJECT_CHARS + 1);

   logic [BUF_W-1:0] subj_buf;
   logic [CNT_W-1:0] chars_left;
   logic             rd_subject_q;
   logic             header_word;
   logic             stream_on;

   // header sits in the first word of a first pass
   assign header_word = rd_subject && first_pass && !rd_subject_q;

   assign stream_on    = !rd_subject && (chars_left != '0);
   assign subject_char = '{valid: stream_on, code: subj_buf[blast_pkg::CHAR_W-1:0]};

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_subject_q <= 1'b0;
         chars_left   <= '0;
      end else begin
         rd_subject_q <= rd_subject;
         if (rd_subject) begin
            chars_left <= CNT_W'(blast_pkg::SUBJECT_CHARS);
         end else if (stream_on) begin
            chars_left <= chars_left - 1'b1;
         end
      end
   end

   // id in the upper half, length byte-swapped in the lower half
   always_ff @(posedge clk) begin
      if (header_word) begin
         hdr.subject_id     <= memory_readdata[63:32];
         hdr.subject_length <= {memory_readdata[7:0],
                                memory_readdata[15:8],
                                memory_readdata[23:16],
                                memory_readdata[31:24]};
      end
   end

   always_ff @(posedge clk) begin
      if (rd_subject && !header_word) begin
         if (first_pass) begin
            subj_buf <= {memory_readdata, subj_buf[BUF_W-1:WORD_W]};
         end else begin
            // lower half already holds the unconsumed words
            subj_buf[BUF_W-1:HALF_W] <= {memory_readdata, subj_buf[BUF_W-1:HALF_W+WORD_W]};
         end
      end else if (stream_on) begin
         subj_buf <= subj_buf >> blast_pkg::CHAR_W;
      end
   end

endmodule

//--- tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
   checks++;
   if (expected !== actual) begin
      errors++;
      $display("FAILED %0t %s expected %h actual %h", $time, name, expected, actual);
   end
endtask

task automatic report_problem(input string what);
   errors++;
   $display("%0t %s", $time, what);
endtask

task automatic preload_memory();
   int a;
   for (a = 0; a < MEM_WORDS; a++) begin
      mem[a] = {32'(a) ^ 32'h5a5a_0000, 32'(a) * 32'h0001_0003};
   end
   for (a = 0; a < 6; a++) begin
      mem[QUERY_BASE + a] = 64'hc3a5_0f1e_7b2d_9604 + 64'(a) * 64'h1357_9bdf_0246_8ace;
   end
   // id 0x1234, length 128 stored byte-reversed
   mem[SUBJECT_BASE] = {32'h0000_1234, 32'h8000_0000};
   seed = 32'h39be_c9f1;
   for (a = 1; a <= 9; a++) begin
      mem[SUBJECT_BASE + a] = {32'($random(seed)), 32'($random(seed))};
   end
endtask

task automatic build_hit_table();
   int g;
   for (g = 0; g < HIT_RECORDS; g++) begin
      if (g % 8 == 7) begin
         hit_table[g] = {8'(g), 8'(g / 8 + 1), 8'd11, 8'(g + 3)};
      end else begin
         hit_table[g] = '0;
      end
   end
endtask

// character i of six words starting at base, least significant first
function automatic logic [2:0] char_at(input int base, input int i);
   logic [383:0] v;
   int k;
   for (k = 0; k < 6; k++) begin
      v[64*k +: 64] = mem[base + k];
   end
   return v[3*i +: 3];
endfunction

task automatic send_command(input logic [7:0] code);
   @(posedge clk);
   #1;
   app_ready = 1'b1;
   app_code = code;
   @(posedge clk);
   #1;
   app_ready = 1'b0;
   app_code = 8'h00;
endtask

task automatic check_idle_outputs(input int cycles);
   int n;
   for (n = 0; n < cycles; n++) begin
      @(negedge clk);
      check_value("memory_write", 64'd0, 64'(memory_write));
      check_value("hit_read", 64'd0, 64'(hit_read));
      check_value("query_char.valid", 64'd0, 64'(query_char.valid));
      check_value("subject_char.valid", 64'd0, 64'(subject_char.valid));
      check_value("array_reset", 64'd0, 64'(array_reset));
      check_value("memory_address", 64'd0, 64'(memory_address));
   end
endtask

task automatic test_reset_idle();
   check_idle_outputs(4);
   // an unknown code leaves the controller idle
   send_command(8'h55);
   check_idle_outputs(10);
endtask

task automatic test_load_query();
   int i;
   int waited;
   query_chars.delete();
   array_reset_pulses = 0;
   send_command(blast_pkg::CMD_READ_QUERY);
   waited = 0;
   while (query_chars.size() < 128 && waited < 200) begin
      @(posedge clk);
      waited++;
   end
   if (query_chars.size() < 128) begin
      report_problem("query stream did not deliver 128 characters");
   end
   repeat (8) @(posedge clk);
   check_value("query char count", 64'd128, 64'(query_chars.size()));
   check_value("array_reset pulses", 64'd1, 64'(array_reset_pulses));
   for (i = 0; i < query_chars.size() && i < 128; i++) begin
      check_value($sformatf("query_char[%0d]", i), 64'(char_at(QUERY_BASE, i)),
                  64'(query_chars[i]));
   end
endtask

task automatic test_search_subject();
   int g;
   int waited;
   int found;
   int n;
   logic [13:0] addr;
   logic [13:0] exp_addr [$];
   logic [63:0] exp_data [$];
   subject_chars.delete();
   wr_addr_q.delete();
   wr_data_q.delete();
   hit_read_cycles = 0;
   header_seen = 1'b0;
   send_command(blast_pkg::CMD_READ_SUBJECT);
   waited = 0;
   while (!header_seen && waited < 400) begin
      @(posedge clk);
      waited++;
   end
   if (!header_seen) begin
      report_problem("header write at the hit base never happened");
   end
   check_value("subject_id", 64'h1234, 64'(subject_id));
   check_value("subject_length", 64'd128, 64'(subject_length));
   check_value("subject char count", 64'd128, 64'(subject_chars.size()));
   // both passes together cover the six data words after the header
   for (g = 0; g < subject_chars.size() && g < 128; g++) begin
      check_value($sformatf("subject_char[%0d]", g), 64'(char_at(SUBJECT_BASE + 1, g)),
                  64'(subject_chars[g]));
   end
   check_value("hit_read cycles", 64'd128, 64'(hit_read_cycles));

   // expected record writes with the wrap above the top address
   addr = 14'(HIT_BASE + 1);
   found = 0;
   for (g = 0; g < HIT_RECORDS; g++) begin
      if (hit_table[g] != '0) begin
         exp_addr.push_back(addr);
         exp_data.push_back({32'b0, hit_table[g]});
         found++;
      end
      if (addr == 14'h3fff) begin
         addr = 14'(HIT_BASE + 1);
      end else begin
         addr = addr + 14'd1;
      end
   end
   exp_addr.push_back(14'(HIT_BASE));
   exp_data.push_back({32'h0000_1234, 32'(found * 8)});

   check_value("write count", 64'(exp_addr.size()), 64'(wr_addr_q.size()));
   n = (wr_addr_q.size() < exp_addr.size()) ? wr_addr_q.size() : exp_addr.size();
   for (g = 0; g < n; g++) begin
      check_value($sformatf("write[%0d] memory_address", g), 64'(exp_addr[g]),
                  64'(wr_addr_q[g]));
      check_value($sformatf("write[%0d] memory_writedata", g), exp_data[g], wr_data_q[g]);
   end

   // back in idle after the header word
   check_idle_outputs(4);
endtask

`endif

//--- tb_blast_top.sv
`timescale 1ns/1ps

module tb_blast_top;

   localparam int QUERY_BASE   = 0;
   localparam int SUBJECT_BASE = 12;
   localparam int HIT_BASE     = 16262;
   localparam int MEM_WORDS    = 16384;
   localparam int HIT_RECORDS  = 128;
   // reset, two query loads and one two-pass search need about 500 cycles
   localparam int TIMEOUT_CYCLES = 2000;

   logic clk;
   logic reset;
   logic app_ready;
   logic [7:0] app_code;
   logic [63:0] memory_readdata;
   blast_pkg::hit_record_t hit;
   logic [13:0] memory_address;
   logic memory_write;
   logic [63:0] memory_writedata;
   blast_pkg::char_strobe_t query_char;
   blast_pkg::char_strobe_t subject_char;
   logic hit_read;
   logic array_reset;
   logic [31:0] subject_id;
   logic [31:0] subject_length;

   // memory model, combinational read
   logic [63:0] mem [0:MEM_WORDS-1];
   integer seed;

   // array model state
   blast_pkg::hit_record_t hit_table [0:HIT_RECORDS-1];
   int hit_idx;

   // monitor logs
   logic [2:0]  query_chars [$];
   logic [2:0]  subject_chars [$];
   logic [13:0] wr_addr_q [$];
   logic [63:0] wr_data_q [$];
   int array_reset_pulses;
   int hit_read_cycles;
   bit header_seen;

   int errors;
   int checks;
   int cycle_count;

   blast_top #(
      .QUERY_BASE   (QUERY_BASE),
      .SUBJECT_BASE (SUBJECT_BASE),
      .HIT_BASE     (HIT_BASE)
   ) uut (
      .clk              (clk),
      .reset            (reset),
      .app_ready        (app_ready),
      .app_code         (app_code),
      .memory_readdata  (memory_readdata),
      .hit              (hit),
      .memory_address   (memory_address),
      .memory_write     (memory_write),
      .memory_writedata (memory_writedata),
      .query_char       (query_char),
      .subject_char     (subject_char),
      .hit_read         (hit_read),
      .array_reset      (array_reset),
      .subject_id       (subject_id),
      .subject_length   (subject_length)
   );

   `include "tb_tasks.svh"

   initial begin
      clk = 1'b0;
   end

   always begin
      #4 clk = ~clk;
   end

   assign memory_readdata = mem[memory_address];

   always_comb begin
      if (hit_idx < HIT_RECORDS) begin
         hit = hit_table[hit_idx];
      end else begin
         hit = '0;
      end
   end

   // one scripted record per hit_read cycle
   always @(posedge clk) begin
      if (reset) begin
         hit_idx <= 0;
      end else if (hit_read) begin
         hit_idx <= hit_idx + 1;
      end
   end

   // outputs are sampled mid-cycle where they are settled
   always @(negedge clk) begin
      if (!reset) begin
         if (query_char.valid) begin
            query_chars.push_back(query_char.code);
         end
         if (subject_char.valid) begin
            subject_chars.push_back(subject_char.code);
         end
         if (array_reset) begin
            array_reset_pulses++;
         end
         if (hit_read) begin
            hit_read_cycles++;
         end
         if (memory_write) begin
            wr_addr_q.push_back(memory_address);
            wr_data_q.push_back(memory_writedata);
            if (memory_address == 14'(HIT_BASE)) begin
               header_seen = 1'b1;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run stopped after %0d cycles", cycle_count);
         $display("Checks failed");
         $finish;
      end
   end

   initial begin
      errors = 0;
      checks = 0;
      cycle_count = 0;
      array_reset_pulses = 0;
      hit_read_cycles = 0;
      header_seen = 1'b0;
      reset = 1'b1;
      app_ready = 1'b0;
      app_code = 8'h00;
      preload_memory();
      build_hit_table();
      repeat (16) @(posedge clk);
      #1 reset = 1'b0;

      test_reset_idle();
      test_load_query();
      test_search_subject();
      test_load_query();

      $display("errors: %0d, checks: %0d", errors, checks);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
